// File: src/fc_pkg.sv
/* Shared types for the fabric controller: word typedefs, opcode and state enums,
   L2 and APU bus structs and the default MAC depth */

package fc_pkg;

  // Widths that carry a meaning
  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;
  typedef logic [4:0]  irq_id_t;
  typedef logic [3:0]  reg_idx_t;

  // Default pipeline depth of the MAC unit
  localparam int unsigned MAC_STAGES_DEFAULT = 2;

  // Instruction opcode, bits 31..28 of the instruction word
  typedef enum logic [3:0] {
    OP_LI   = 4'd0,
    OP_ADD  = 4'd1,
    OP_LW   = 4'd2,
    OP_SW   = 4'd3,
    OP_MAC  = 4'd4,
    OP_WFI  = 4'd5,
    OP_JMP  = 4'd6,
    OP_HALT = 4'd7
  } opcode_e;

  // Core sequencer
  typedef enum logic [2:0] {
    ST_FETCH,
    ST_WAIT_INSTR,
    ST_EXEC,
    ST_WAIT_DATA,
    ST_WAIT_APU,
    ST_WAIT_IRQ,
    ST_ACK,
    ST_HALTED
  } core_state_e;

  //*******************************************************************
  // L2 bus, req/gnt/rvalid
  //*******************************************************************
  typedef struct packed {
    logic       req;
    addr_t      addr;
    logic       wen;    // Low for a write
    word_t      wdata;
    logic [3:0] be;
  } l2_req_t;

  typedef struct packed {
    logic  gnt;
    logic  rvalid;
    word_t rdata;
    logic  err;
  } l2_rsp_t;

  //*******************************************************************
  // APU interface to the MAC unit
  //*******************************************************************
  typedef struct packed {
    logic  req;
    word_t op_a;
    word_t op_b;
    word_t op_c;
  } apu_req_t;

  typedef struct packed {
    logic  gnt;
    logic  rvalid;
    word_t result;
  } apu_rsp_t;

endpackage

// File: src/fc_irq_latch.sv
/* Sticky event latch, one pending bit per event line, cleared by acknowledge */

`timescale 1ns/1ns

module fc_irq_latch
  import fc_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic [31:0] events_i,
  input  logic        ack_i,
  input  irq_id_t     ack_id_i,
  output logic [31:0] pending_o
);

  logic [31:0] pending_q;
  logic [31:0] ack_mask;

  // One-hot mask of the bit being acknowledged
  always_comb begin
    ack_mask = '0;
    if (ack_i) begin
      ack_mask[ack_id_i] = 1'b1;
    end
  end

  // Events OR into the pending bits, ack wins on the same bit
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= '0;
    end else begin
      pending_q <= (pending_q | events_i) & ~ack_mask;
    end
  end

  assign pending_o = pending_q;

endmodule

// File: src/fc_apu_mac.sv
/* Pipelined 32-bit multiply-accumulate unit behind an APU req/gnt/rvalid port */

`timescale 1ns/1ns

module fc_apu_mac
  import fc_pkg::*;
#(
  parameter int unsigned MAC_STAGES = MAC_STAGES_DEFAULT
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  apu_req_t apu_req_i,
  output apu_rsp_t apu_rsp_o
);

  logic  [MAC_STAGES-1:0] valid_q;
  word_t [MAC_STAGES-1:0] res_q;
  logic                   accept;

  // Input stage is free when it holds no operation
  assign apu_rsp_o.gnt = ~valid_q[0];
  assign accept        = apu_req_i.req & ~valid_q[0];

  //*******************************************************************
  // Valid pipeline
  //*******************************************************************
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else begin
      valid_q[0] <= accept;
      for (int k = 1; k < MAC_STAGES; k++) begin
        valid_q[k] <= valid_q[k-1];
      end
    end
  end

  //*******************************************************************
  // Result pipeline
  //*******************************************************************
  always_ff @(posedge clk_i) begin
    // Product and sum in the first stage, low 32 bits kept
    if (accept) begin
      res_q[0] <= apu_req_i.op_a * apu_req_i.op_b + apu_req_i.op_c;
    end
    for (int k = 1; k < MAC_STAGES; k++) begin
      res_q[k] <= res_q[k-1];
    end
  end

  // Result leaves MAC_STAGES cycles after the grant
  assign apu_rsp_o.rvalid = valid_q[MAC_STAGES-1];
  assign apu_rsp_o.result = res_q[MAC_STAGES-1];

endmodule

// File: src/fc_core.sv
/* Controller core: fetch, decode, 16-entry register file, L2 load/store,
   MAC issue to the APU and interrupt wait/acknowledge */

`timescale 1ns/1ns

module fc_core
  import fc_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        fetch_en_i,
  input  logic        debug_req_i,
  input  addr_t       boot_addr_i,
  output l2_req_t     instr_req_o,
  input  l2_rsp_t     instr_rsp_i,
  output l2_req_t     data_req_o,
  input  l2_rsp_t     data_rsp_i,
  output apu_req_t    apu_req_o,
  input  apu_rsp_t    apu_rsp_i,
  input  logic [31:0] irq_pending_i,
  output logic        irq_ack_o,
  output irq_id_t     irq_ack_id_o,
  output logic        halted_o
);

  core_state_e state_q, state_d;
  addr_t       pc_q, pc_d;
  word_t       instr_q;
  word_t       rf_q [16];
  logic        fetch_hold_q;
  logic        dbg_pend_q;
  irq_id_t     ack_id_q;

  opcode_e     op;
  reg_idx_t    rd_idx;
  reg_idx_t    rs_idx;
  word_t       imm;
  word_t       rd_val;
  word_t       rs_val;
  word_t       r1_val;
  logic        halt_now;
  logic        fetch_req;
  logic        rf_we;
  reg_idx_t    rf_waddr;
  word_t       rf_wdata;

  // Lowest set bit wins
  function automatic irq_id_t lowest_id(input logic [31:0] pend);
    irq_id_t id;
    id = '0;
    for (int i = 31; i >= 0; i--) begin
      if (pend[i]) begin
        id = irq_id_t'(i);
      end
    end
    return id;
  endfunction

  //*******************************************************************
  // Decode and register read
  //*******************************************************************
  assign op     = opcode_e'(instr_q[31:28]);
  assign rd_idx = instr_q[27:24];
  assign rs_idx = instr_q[23:20];
  assign imm    = {12'b0, instr_q[19:0]};

  // r0 reads as zero
  assign rd_val = (rd_idx == '0) ? '0 : rf_q[rd_idx];
  assign rs_val = (rs_idx == '0) ? '0 : rf_q[rs_idx];
  assign r1_val = rf_q[1];

  // Debug is taken at a boundary, never in the middle of a held fetch
  assign halt_now  = (debug_req_i | dbg_pend_q) & ~fetch_hold_q;
  assign fetch_req = (state_q == ST_FETCH) & ~halt_now & (fetch_en_i | fetch_hold_q);

  // Instruction port, read only
  always_comb begin
    instr_req_o.req   = fetch_req;
    instr_req_o.addr  = pc_q;
    instr_req_o.wen   = 1'b1;
    instr_req_o.wdata = '0;
    instr_req_o.be    = 4'hf;
  end

  // Data port, held in execute until granted
  always_comb begin
    data_req_o.req   = (state_q == ST_EXEC) & ((op == OP_LW) | (op == OP_SW));
    data_req_o.addr  = rs_val + imm;
    data_req_o.wen   = (op != OP_SW);
    data_req_o.wdata = rd_val;
    data_req_o.be    = 4'hf;
  end

  // MAC issue: rd = rs * r1 + rd
  always_comb begin
    apu_req_o.req  = (state_q == ST_EXEC) & (op == OP_MAC);
    apu_req_o.op_a = rs_val;
    apu_req_o.op_b = r1_val;
    apu_req_o.op_c = rd_val;
  end

  assign irq_ack_o    = (state_q == ST_ACK);
  assign irq_ack_id_o = ack_id_q;
  assign halted_o     = (state_q == ST_HALTED);

  //*******************************************************************
  // Sequencer
  //*******************************************************************
  always_comb begin
    state_d  = state_q;
    pc_d     = pc_q;
    rf_we    = 1'b0;
    rf_waddr = rd_idx;
    rf_wdata = imm;
    unique case (state_q)
      ST_FETCH: begin
        if (halt_now) begin
          state_d = ST_HALTED;
        end else if (fetch_req && instr_rsp_i.gnt) begin
          state_d = ST_WAIT_INSTR;
        end
      end
      ST_WAIT_INSTR: begin
        if (instr_rsp_i.rvalid) begin
          state_d = ST_EXEC;
        end
      end
      ST_EXEC: begin
        case (op)
          OP_LI: begin
            rf_we   = 1'b1;
            pc_d    = pc_q + 32'd4;
            state_d = ST_FETCH;
          end
          OP_ADD: begin
            rf_we    = 1'b1;
            rf_wdata = rd_val + rs_val;
            pc_d     = pc_q + 32'd4;
            state_d  = ST_FETCH;
          end
          OP_LW, OP_SW: begin
            if (data_rsp_i.gnt) begin
              state_d = ST_WAIT_DATA;
            end
          end
          OP_MAC: begin
            if (apu_rsp_i.gnt) begin
              state_d = ST_WAIT_APU;
            end
          end
          OP_WFI: state_d = ST_WAIT_IRQ;
          OP_JMP: begin
            pc_d    = {imm[29:0], 2'b00};
            state_d = ST_FETCH;
          end
          // HALT and undefined opcodes stop the core
          default: state_d = ST_HALTED;
        endcase
      end
      ST_WAIT_DATA: begin
        if (data_rsp_i.rvalid) begin
          rf_we    = (op == OP_LW);
          rf_wdata = data_rsp_i.rdata;
          pc_d     = pc_q + 32'd4;
          state_d  = ST_FETCH;
        end
      end
      ST_WAIT_APU: begin
        if (apu_rsp_i.rvalid) begin
          rf_we    = 1'b1;
          rf_wdata = apu_rsp_i.result;
          pc_d     = pc_q + 32'd4;
          state_d  = ST_FETCH;
        end
      end
      ST_WAIT_IRQ: begin
        if (|irq_pending_i) begin
          state_d = ST_ACK;
        end else if (debug_req_i || dbg_pend_q) begin
          state_d = ST_HALTED;
        end
      end
      ST_ACK: begin
        // Acknowledged id goes to r15
        rf_we    = 1'b1;
        rf_waddr = 4'd15;
        rf_wdata = {27'b0, ack_id_q};
        pc_d     = pc_q + 32'd4;
        state_d  = ST_FETCH;
      end
      default: ;  // Halted until reset
    endcase
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= ST_FETCH;
      pc_q         <= boot_addr_i;
      fetch_hold_q <= 1'b0;
      dbg_pend_q   <= 1'b0;
      ack_id_q     <= '0;
    end else begin
      state_q      <= state_d;
      pc_q         <= pc_d;
      fetch_hold_q <= fetch_req & ~instr_rsp_i.gnt;
      if (state_q == ST_HALTED) begin
        dbg_pend_q <= 1'b0;
      end else if (debug_req_i) begin
        dbg_pend_q <= 1'b1;
      end
      if (state_q == ST_WAIT_IRQ) begin
        ack_id_q <= lowest_id(irq_pending_i);
      end
    end
  end

  // Instruction register and register file
  always_ff @(posedge clk_i) begin
    if (state_q == ST_WAIT_INSTR && instr_rsp_i.rvalid) begin
      instr_q <= instr_rsp_i.rdata;
    end
    if (rf_we) begin
      rf_q[rf_waddr] <= rf_wdata;
    end
  end

endmodule

// File: src/fc_subsystem.sv
/* Fabric controller top level: core, interrupt latch and MAC unit */

`timescale 1ns/1ns

module fc_subsystem
  import fc_pkg::*;
#(
  parameter int unsigned MAC_STAGES = MAC_STAGES_DEFAULT
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        fetch_en_i,
  input  logic        debug_req_i,
  input  addr_t       boot_addr_i,
  input  logic [31:0] events_i,

  // L2 ports, straight from the core
  output l2_req_t     l2_instr_req_o,
  input  l2_rsp_t     l2_instr_rsp_i,
  output l2_req_t     l2_data_req_o,
  input  l2_rsp_t     l2_data_rsp_i,

  output logic        core_irq_ack_o,
  output irq_id_t     core_irq_ack_id_o,
  output logic        halted_o
);

  // Interrupt path
  logic [31:0] irq_pending;
  logic        irq_ack;
  irq_id_t     irq_ack_id;

  // Core to MAC unit
  apu_req_t    apu_req;
  apu_rsp_t    apu_rsp;

  assign core_irq_ack_o    = irq_ack;
  assign core_irq_ack_id_o = irq_ack_id;

  fc_core i_core (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .fetch_en_i    (fetch_en_i),
    .debug_req_i   (debug_req_i),
    .boot_addr_i   (boot_addr_i),
    .instr_req_o   (l2_instr_req_o),
    .instr_rsp_i   (l2_instr_rsp_i),
    .data_req_o    (l2_data_req_o),
    .data_rsp_i    (l2_data_rsp_i),
    .apu_req_o     (apu_req),
    .apu_rsp_i     (apu_rsp),
    .irq_pending_i (irq_pending),
    .irq_ack_o     (irq_ack),
    .irq_ack_id_o  (irq_ack_id),
    .halted_o      (halted_o)
  );

  fc_irq_latch i_irq_latch (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .events_i  (events_i),
    .ack_i     (irq_ack),
    .ack_id_i  (irq_ack_id),
    .pending_o (irq_pending)
  );

  fc_apu_mac #(
    .MAC_STAGES (MAC_STAGES)
  ) i_apu_mac (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .apu_req_i (apu_req),
    .apu_rsp_o (apu_rsp)
  );

endmodule

// File: tests/fc_subsystem_chk.sv
/* Bound protocol checks: L2 request stability, rvalid only after a grant,
   single-cycle interrupt acknowledge */

`timescale 1ns/1ns

module fc_subsystem_chk
  import fc_pkg::*;
(
  input logic    clk_i,
  input logic    rst_ni,
  input l2_req_t instr_req_i,
  input l2_rsp_t instr_rsp_i,
  input l2_req_t data_req_i,
  input l2_rsp_t data_rsp_i,
  input logic    irq_ack_i
);

  // Granted and still waiting for rvalid, per port
  logic instr_out_q;
  logic data_out_q;

  // Number of assertion failures so far
  int unsigned fail_count = 0;

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      instr_out_q <= 1'b0;
      data_out_q  <= 1'b0;
    end else begin
      instr_out_q <= (instr_out_q & ~instr_rsp_i.rvalid) |
                     (instr_req_i.req & instr_rsp_i.gnt);
      data_out_q  <= (data_out_q & ~data_rsp_i.rvalid) |
                     (data_req_i.req & data_rsp_i.gnt);
    end
  end

  //*******************************************************************
  // L2 protocol on both ports
  //*******************************************************************
  instr_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_req_i.req && !instr_rsp_i.gnt |=> $stable(instr_req_i))
  else begin
    $error("instruction request changed before its grant");
    fail_count++;
  end

  data_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_req_i.req && !data_rsp_i.gnt |=> $stable(data_req_i))
  else begin
    $error("data request changed before its grant");
    fail_count++;
  end

  instr_rvalid_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_rsp_i.rvalid |-> instr_out_q)
  else begin
    $error("instruction rvalid without an outstanding grant");
    fail_count++;
  end

  data_rvalid_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_rsp_i.rvalid |-> data_out_q)
  else begin
    $error("data rvalid without an outstanding grant");
    fail_count++;
  end

  // Acknowledge lasts exactly one cycle
  irq_ack_pulse_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    irq_ack_i |=> !irq_ack_i)
  else begin
    $error("irq acknowledge held longer than one cycle");
    fail_count++;
  end

endmodule

bind fc_subsystem fc_subsystem_chk i_chk (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .instr_req_i (l2_instr_req_o),
  .instr_rsp_i (l2_instr_rsp_i),
  .data_req_i  (l2_data_req_o),
  .data_rsp_i  (l2_data_rsp_i),
  .irq_ack_i   (core_irq_ack_o)
);

// File: tests/tb_fc_subsystem.sv
/* Testbench for the fabric controller: clock, reset, L2 memory model with
   random grant delay, directed tests and the closing report */

`timescale 1ns/1ns

module tb_fc_subsystem
  import fc_pkg::*;
();

  localparam int MEM_WORDS = 1024;
  localparam int TIMEOUT   = 3000;

  logic        clk_i;
  logic        rst_ni;
  logic        fetch_en;
  logic        debug_req;
  addr_t       boot_addr;
  logic [31:0] events;
  l2_req_t     instr_req;
  l2_rsp_t     instr_rsp;
  l2_req_t     data_req;
  l2_rsp_t     data_rsp;
  logic        irq_ack;
  irq_id_t     irq_ack_id;
  logic        halted;

  // Shared word memory with port 0 for instructions and port 1 for data
  word_t       mem [MEM_WORDS];
  l2_req_t     port_req [2];
  l2_rsp_t     port_rsp [2];
  int unsigned gnt_delay [2];
  logic        rvalid_n [2];
  word_t       rdata_n [2];

  // Observed behavior is cleared while reset is low
  int unsigned store_count;
  int unsigned fetch_req_cycles;
  logic        fetch_seen;
  addr_t       first_fetch;
  irq_id_t     ack_ids [$];

  logic [31:0] lfsr_q = 32'h94c8cc21;
  int          err_count;
  int          check_count;
  int          test_count;

  fc_subsystem #(
    .MAC_STAGES (MAC_STAGES_DEFAULT)
  ) i_dut (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .fetch_en_i        (fetch_en),
    .debug_req_i       (debug_req),
    .boot_addr_i       (boot_addr),
    .events_i          (events),
    .l2_instr_req_o    (instr_req),
    .l2_instr_rsp_i    (instr_rsp),
    .l2_data_req_o     (data_req),
    .l2_data_rsp_i     (data_rsp),
    .core_irq_ack_o    (irq_ack),
    .core_irq_ack_id_o (irq_ack_id),
    .halted_o          (halted)
  );

  assign port_req[0] = instr_req;
  assign port_req[1] = data_req;
  assign instr_rsp   = port_rsp[0];
  assign data_rsp    = port_rsp[1];

  initial begin
    clk_i = 1'b0;
    forever begin
      #4 clk_i = ~clk_i;
    end
  end

  //*********************************************************************
  // Helpers
  //*********************************************************************
  // Taps of x^32 + x^22 + x^2 + x + 1 and one step per bit taken
  function automatic logic lfsr_bit();
    logic fb;
    fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
  endfunction

  function automatic word_t rand_bits(input int unsigned n);
    word_t v;
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_bit()};
    end
    return v;
  endfunction

  // opcode | rd | rs | imm20
  function automatic word_t enc(input opcode_e op, input int unsigned rd,
                                input int unsigned rs, input int unsigned imm);
    return {op, rd[3:0], rs[3:0], imm[19:0]};
  endfunction

  function automatic word_t fill_word(input int unsigned idx);
    return 32'h5a5a_0000 | (idx << 2);
  endfunction

  function automatic word_t mem_at(input addr_t a);
    return mem[a[11:2]];
  endfunction

  task automatic poke(input addr_t a, input word_t v);
    mem[a[11:2]] = v;
  endtask

  task automatic check_eq(input string what, input word_t got, input word_t exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("[ERROR] %s: got 0x%08h, expected 0x%08h", what, got, exp);
    end
  endtask

  //*********************************************************************
  // L2 memory model and bus monitor
  //*********************************************************************
  initial begin : l2_model
    logic [9:0] idx;
    for (int p = 0; p < 2; p++) begin
      port_rsp[p]  = '0;
      gnt_delay[p] = 0;
      rvalid_n[p]  = 1'b0;
      rdata_n[p]   = '0;
    end
    forever begin
      @(negedge clk_i);
      if (!rst_ni) begin
        store_count      = 0;
        fetch_req_cycles = 0;
        fetch_seen       = 1'b0;
        first_fetch      = '0;
        ack_ids.delete();
      end else begin
        if (instr_req.req) begin
          fetch_req_cycles++;
          if (!fetch_seen) begin
            first_fetch = instr_req.addr;
            fetch_seen  = 1'b1;
          end
        end
        if (irq_ack) begin
          ack_ids.push_back(irq_ack_id);
        end
      end
      for (int p = 0; p < 2; p++) begin
        rvalid_n[p] = 1'b0;
        if (!rst_ni) begin
          gnt_delay[p] = 0;
        end else if (port_req[p].req && port_rsp[p].gnt) begin
          // Handshake at the coming edge and rvalid one cycle later
          idx = port_req[p].addr[11:2];
          if (p == 0) begin
            check_eq("l2_instr_req_o.wen", word_t'(port_req[p].wen), 32'd1);
            check_eq("l2_instr_req_o.be", word_t'(port_req[p].be), 32'hf);
          end else begin
            check_eq("l2_data_req_o.be", word_t'(port_req[p].be), 32'hf);
          end
          if (!port_req[p].wen) begin
            mem[idx] = port_req[p].wdata;
            if (p == 1) begin
              store_count++;
            end
          end
          rdata_n[p]   = mem[idx];
          rvalid_n[p]  = 1'b1;
          gnt_delay[p] = rand_bits(2);
        end else if (port_req[p].req && gnt_delay[p] != 0) begin
          gnt_delay[p]--;
        end
      end
      @(posedge clk_i);
      #1;
      for (int p = 0; p < 2; p++) begin
        port_rsp[p].gnt    = (gnt_delay[p] == 0);
        port_rsp[p].rvalid = rvalid_n[p];
        port_rsp[p].rdata  = rvalid_n[p] ? rdata_n[p] : '0;
        port_rsp[p].err    = 1'b0;
      end
    end
  end

  //*********************************************************************
  // Test control
  //*********************************************************************
  task automatic apply_reset(input addr_t boot);
    rst_ni    = 1'b0;
    fetch_en  = 1'b0;
    debug_req = 1'b0;
    events    = '0;
    boot_addr = boot;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i[9:0]] = fill_word(i);
    end
    repeat (10) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
  endtask

  task automatic load_program(input addr_t base, input word_t prog[$]);
    for (int k = 0; k < prog.size(); k++) begin
      poke(base + addr_t'(k * 4), prog[k]);
    end
  endtask

  task automatic wait_halted(input int max_cycles);
    int n;
    n = 0;
    while (!halted && n < max_cycles) begin
      @(posedge clk_i);
      #1;
      n++;
    end
    if (!halted) begin
      err_count++;
      $display("Core did not halt within %0d cycles", max_cycles);
    end
  endtask

  task automatic wait_stores(input int unsigned target, input int max_cycles);
    int n;
    n = 0;
    while (store_count < target && n < max_cycles) begin
      @(posedge clk_i);
      #1;
      n++;
    end
    if (store_count < target) begin
      err_count++;
      $display("Only %0d of %0d data stores seen before the timeout", store_count, target);
    end
  endtask

  task automatic end_test(input string name, input int errs_before);
    test_count++;
    if (err_count == errs_before) begin
      $display("Test %s: ok", name);
    end else begin
      $display("Test %s: %0d errors", name, err_count - errs_before);
    end
  endtask

  //*********************************************************************
  // Directed tests
  //*********************************************************************
  task automatic test_boot_store();
    word_t a;
    word_t b;
    word_t prog[$];
    int    errs;
    errs = err_count;
    a    = rand_bits(20);
    b    = rand_bits(20);
    apply_reset(32'h0000_0100);
    prog.push_back(enc(OP_LI, 2, 0, a));
    prog.push_back(enc(OP_LI, 3, 0, b));
    prog.push_back(enc(OP_ADD, 2, 3, 0));
    prog.push_back(enc(OP_SW, 2, 0, 32'h200));
    prog.push_back(enc(OP_ADD, 3, 2, 0));
    prog.push_back(enc(OP_SW, 3, 0, 32'h204));
    prog.push_back(enc(OP_HALT, 0, 0, 0));
    load_program(32'h0000_0100, prog);
    fetch_en = 1'b1;
    wait_halted(TIMEOUT);
    check_eq("first fetch seen", word_t'(fetch_seen), 32'd1);
    check_eq("l2_instr_req_o.addr", first_fetch, 32'h0000_0100);
    check_eq("mem[0x200]", mem_at(32'h200), a + b);
    check_eq("mem[0x204]", mem_at(32'h204), a + b + b);
    end_test("boot_store", errs);
  endtask

  task automatic test_load_store();
    word_t w0;
    word_t w1;
    word_t w2;
    word_t prog[$];
    int    errs;
    errs = err_count;
    w0   = rand_bits(32);
    w1   = rand_bits(32);
    w2   = rand_bits(32);
    apply_reset(32'h0);
    poke(32'h300, w0);
    poke(32'h304, w1);
    poke(32'h308, w2);
    prog.push_back(enc(OP_LI, 4, 0, 32'h300));
    prog.push_back(enc(OP_LW, 5, 4, 0));
    prog.push_back(enc(OP_LW, 6, 4, 4));
    prog.push_back(enc(OP_LW, 7, 4, 8));
    prog.push_back(enc(OP_ADD, 5, 6, 0));
    prog.push_back(enc(OP_ADD, 5, 7, 0));
    prog.push_back(enc(OP_SW, 5, 4, 32'h10));
    prog.push_back(enc(OP_ADD, 6, 7, 0));
    prog.push_back(enc(OP_SW, 6, 4, 32'h14));
    prog.push_back(enc(OP_HALT, 0, 0, 0));
    load_program(32'h0, prog);
    fetch_en = 1'b1;
    wait_halted(TIMEOUT);
    check_eq("mem[0x310]", mem_at(32'h310), w0 + w1 + w2);
    check_eq("mem[0x314]", mem_at(32'h314), w1 + w2);
    end_test("load_store", errs);
  endtask

  task automatic test_mac();
    word_t a;
    word_t b;
    word_t c;
    word_t e1;
    word_t e2;
    word_t prog[$];
    int    errs;
    errs = err_count;
    a    = rand_bits(32);
    b    = rand_bits(32);
    c    = rand_bits(32);
    // Low 32 bits of rs * r1 + rd
    e1   = b * a + c;
    e2   = b * a + e1;
    apply_reset(32'h0);
    poke(32'h380, a);
    poke(32'h384, b);
    poke(32'h388, c);
    prog.push_back(enc(OP_LW, 1, 0, 32'h380));
    prog.push_back(enc(OP_LW, 2, 0, 32'h384));
    prog.push_back(enc(OP_LW, 3, 0, 32'h388));
    prog.push_back(enc(OP_MAC, 3, 2, 0));
    prog.push_back(enc(OP_SW, 3, 0, 32'h400));
    prog.push_back(enc(OP_MAC, 3, 2, 0));
    prog.push_back(enc(OP_SW, 3, 0, 32'h404));
    prog.push_back(enc(OP_HALT, 0, 0, 0));
    load_program(32'h0, prog);
    fetch_en = 1'b1;
    wait_halted(TIMEOUT);
    check_eq("mem[0x400]", mem_at(32'h400), e1);
    check_eq("mem[0x404]", mem_at(32'h404), e2);
    end_test("mac", errs);
  endtask

  task automatic test_interrupts();
    word_t prog[$];
    int    errs;
    errs = err_count;
    apply_reset(32'h0);
    prog.push_back(enc(OP_WFI, 0, 0, 0));
    prog.push_back(enc(OP_SW, 15, 0, 32'h500));
    prog.push_back(enc(OP_WFI, 0, 0, 0));
    prog.push_back(enc(OP_SW, 15, 0, 32'h504));
    prog.push_back(enc(OP_HALT, 0, 0, 0));
    load_program(32'h0, prog);
    fetch_en = 1'b1;
    @(posedge clk_i);
    #1;
    // Events 9 and 5 in the same cycle
    events = (32'd1 << 9) | (32'd1 << 5);
    @(posedge clk_i);
    #1;
    events = '0;
    wait_halted(TIMEOUT);
    check_eq("irq ack count", word_t'(ack_ids.size()), 32'd2);
    if (ack_ids.size() >= 2) begin
      check_eq("core_irq_ack_id_o first", word_t'(ack_ids[0]), 32'd5);
      check_eq("core_irq_ack_id_o second", word_t'(ack_ids[1]), 32'd9);
    end
    check_eq("mem[0x500]", mem_at(32'h500), 32'd5);
    check_eq("mem[0x504]", mem_at(32'h504), 32'd9);
    end_test("interrupts", errs);
  endtask

  task automatic test_fetch_en_debug();
    word_t       prog[$];
    int unsigned stores;
    int          errs;
    errs = err_count;
    apply_reset(32'h0);
    // Endless counting loop with one store per pass
    prog.push_back(enc(OP_LI, 2, 0, 0));
    prog.push_back(enc(OP_LI, 3, 0, 1));
    prog.push_back(enc(OP_ADD, 2, 3, 0));
    prog.push_back(enc(OP_SW, 2, 0, 32'h600));
    prog.push_back(enc(OP_JMP, 0, 0, 2));
    load_program(32'h0, prog);
    repeat (20) @(posedge clk_i);
    #1;
    check_eq("l2_instr_req_o.req cycles", fetch_req_cycles, 32'd0);
    fetch_en = 1'b1;
    wait_stores(3, TIMEOUT);
    debug_req = 1'b1;
    @(posedge clk_i);
    #1;
    debug_req = 1'b0;
    wait_halted(TIMEOUT);
    stores = store_count;
    repeat (20) @(posedge clk_i);
    #1;
    check_eq("data stores after halt", store_count, stores);
    check_eq("halted_o", word_t'(halted), 32'd1);
    check_eq("mem[0x600]", mem_at(32'h600), stores);
    end_test("fetch_en_debug", errs);
  endtask

  task automatic test_jump();
    word_t prog[$];
    int    errs;
    errs = err_count;
    apply_reset(32'h0);
    prog.push_back(enc(OP_LI, 2, 0, 32'h11));
    prog.push_back(enc(OP_SW, 2, 0, 32'h700));
    prog.push_back(enc(OP_JMP, 0, 0, 5));
    prog.push_back(enc(OP_SW, 2, 0, 32'h704));
    prog.push_back(enc(OP_SW, 2, 0, 32'h708));
    prog.push_back(enc(OP_SW, 2, 0, 32'h70c));
    prog.push_back(enc(OP_HALT, 0, 0, 0));
    load_program(32'h0, prog);
    fetch_en = 1'b1;
    wait_halted(TIMEOUT);
    check_eq("mem[0x700]", mem_at(32'h700), 32'h11);
    check_eq("mem[0x704]", mem_at(32'h704), fill_word(32'h704 >> 2));
    check_eq("mem[0x708]", mem_at(32'h708), fill_word(32'h708 >> 2));
    check_eq("mem[0x70c]", mem_at(32'h70c), 32'h11);
    check_eq("data store count", store_count, 32'd2);
    end_test("jump", errs);
  endtask

  initial begin
    rst_ni      = 1'b0;
    fetch_en    = 1'b0;
    debug_req   = 1'b0;
    boot_addr   = '0;
    events      = '0;
    err_count   = 0;
    check_count = 0;
    test_count  = 0;
    test_boot_store();
    test_load_store();
    test_mac();
    test_interrupts();
    test_fetch_en_debug();
    test_jump();
    if (i_dut.i_chk.fail_count != 0) begin
      err_count++;
      $display("Protocol assertions failed %0d times", i_dut.i_chk.fail_count);
    end
    $display("Tests: %0d, checks: %0d, errors: %0d", test_count, check_count, err_count);
    if (err_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: fc_subsystem.f
src/fc_pkg.sv
src/fc_irq_latch.sv
src/fc_apu_mac.sv
src/fc_core.sv
src/fc_subsystem.sv
tests/fc_subsystem_chk.sv
tests/tb_fc_subsystem.sv

// File: Makefile
# Verilator flow for the fabric controller subsystem

.PHONY: all lint clean

# Build, run and scan the log for the fail message
all: obj_dir/Vtb_fc_subsystem
	./obj_dir/Vtb_fc_subsystem +verilator+error+limit+1000 > sim.log 2>&1; \
	  status=$$?; \
	  cat sim.log; \
	  if grep -q "Simulation failed" sim.log; then exit 1; fi; \
	  exit $$status

obj_dir/Vtb_fc_subsystem: fc_subsystem.f $(wildcard src/*.sv tests/*.sv)
	verilator --binary --timing --assert -j 0 \
	  --top-module tb_fc_subsystem -f fc_subsystem.f

# Lint of the RTL on its own
lint:
	verilator --lint-only -Wall --top-module fc_subsystem \
	  src/fc_pkg.sv src/fc_irq_latch.sv src/fc_apu_mac.sv \
	  src/fc_core.sv src/fc_subsystem.sv

clean:
	rm -rf obj_dir sim.log
